/* hw/aluPkg.sv */
package aluPkg;

    // Operand and result width of the execution unit
    localparam int dataWidth = 16;

    // Operation codes, 10 to 15 are illegal
    typedef enum logic [3:0] {
        opAdd  = 4'd0,  // Signed add
        opAddu = 4'd1,  // Unsigned add
        opSub  = 4'd2,  // Signed subtract
        opSubu = 4'd3,  // Unsigned subtract
        opInc  = 4'd4,  // A + 1
        opDec  = 4'd5,  // A - 1
        opAnd  = 4'd6,
        opOr   = 4'd7,
        opXor  = 4'd8,
        opShl  = 4'd9   // A shifted by B[3:0]
    } aluOpT;

    // One request, 37 bits
    typedef struct packed {
        aluOpT                op;
        logic [dataWidth-1:0] a;
        logic [dataWidth-1:0] b;
        logic                 coe;  // Carry output enable
    } aluReqT;

    // Status flags
    typedef struct packed {
        logic carry;
        logic overflow;  // Signed ops only
        logic zero;
        logic negative;
    } aluFlagsT;

    // One response, 20 bits
    typedef struct packed {
        logic [dataWidth-1:0] result;
        aluFlagsT             flags;
    } aluRespT;

endpackage

/* hw/cla16.sv */
`timescale 1ns/10ps

module cla16 #(
    parameter int width = 16
) (
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic [width-1:0] sum,
    output logic             cOut
);

    localparam int groups = width / 4;

    logic [width-1:0]  p;     // Bit propagate
    logic [width-1:0]  g;     // Bit generate
    logic [groups-1:0] grpP;
    logic [groups-1:0] grpG;
    logic [groups:0]   grpC;  // Carry into each group

    assign p = a ^ b;
    assign g = a & b;

    for (genvar n = 0; n < groups; n++) begin : grp
        logic [3:0] gp;
        logic [3:0] gg;
        logic [3:0] gc;  // Carry into each bit of the group

        assign gp = p[4*n +: 4];
        assign gg = g[4*n +: 4];

        assign grpP[n] = &gp;
        assign grpG[n] = gg[3] | (gp[3] & gg[2]) | (gp[3] & gp[2] & gg[1])
                       | (gp[3] & gp[2] & gp[1] & gg[0]);

        // Lookahead inside the group
        assign gc[0] = grpC[n];
        assign gc[1] = gg[0] | (gp[0] & gc[0]);
        assign gc[2] = gg[1] | (gp[1] & gg[0]) | (gp[1] & gp[0] & gc[0]);
        assign gc[3] = gg[2] | (gp[2] & gg[1]) | (gp[2] & gp[1] & gg[0])
                     | (gp[2] & gp[1] & gp[0] & gc[0]);

        assign sum[4*n +: 4] = gp ^ gc;
    end

    // Second level, every group carry formed directly from group P and G
    always_comb begin
        logic term;
        grpC[0] = 1'b0;  // No carry input
        for (int i = 0; i < groups; i++) begin
            grpC[i+1] = 1'b0;
            for (int j = 0; j <= i; j++) begin
                term = grpG[j];
                for (int k = j + 1; k <= i; k++) begin
                    term = term & grpP[k];
                end
                grpC[i+1] = grpC[i+1] | term;
            end
        end
    end

    assign cOut = grpC[groups];

endmodule

/* hw/addSubUnit.sv */
`timescale 1ns/10ps

module addSubUnit #(
    parameter int width = 16
) (
    input  aluPkg::aluOpT    op,
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    input  logic             coe,
    output logic [width-1:0] result,
    output logic             carry,
    output logic             overflow
);

    import aluPkg::*;

    localparam int msb = width - 1;

    logic [width-1:0] addA;
    logic [width-1:0] addB;
    logic [width-1:0] sum;
    logic             sumCarry;
    logic             isArith;
    logic             isSigned;  // Ops that report overflow

    cla16 #(
        .width(width)
    ) adder (
        .a   (addA),
        .b   (addB),
        .sum (sum),
        .cOut(sumCarry)
    );

    always_comb begin
        addA     = a;
        isArith  = 1'b1;
        isSigned = 1'b0;
        case (op)
            opAdd: begin
                addB     = b;
                isSigned = 1'b1;
            end
            opAddu: addB = b;
            opSub: begin
                addB     = ~b + width'(1);  // Two's complement of B
                isSigned = 1'b1;
            end
            opSubu: addB = ~b + width'(1);
            opInc: begin
                addB     = {{(width-1){1'b0}}, 1'b1};
                isSigned = 1'b1;
            end
            opDec: begin
                addB     = '1;
                isSigned = 1'b1;
            end
            default: begin
                addA    = '0;  // Adder idles at zero
                addB    = '0;
                isArith = 1'b0;
            end
        endcase
    end

    assign result   = isArith ? sum : '0;
    assign carry    = isArith & coe & sumCarry;
    // Same operand signs but the sum flips sign
    assign overflow = isSigned & (addA[msb] == addB[msb]) & (sum[msb] != addA[msb]);

endmodule

/* hw/logicShiftUnit.sv */
`timescale 1ns/10ps

module logicShiftUnit #(
    parameter int width = 16
) (
    input  aluPkg::aluOpT    op,
    input  logic [width-1:0] a,
    input  logic [width-1:0] b,
    output logic [width-1:0] result
);

    import aluPkg::*;

    logic [3:0] shiftAmt;

    assign shiftAmt = b[3:0];  // Only the low four bits count

    always_comb begin
        case (op)
            opAnd:   result = a & b;
            opOr:    result = a | b;
            opXor:   result = a ^ b;
            opShl:   result = a << shiftAmt;  // Zero fill
            default: result = '0;
        endcase
    end

endmodule

/* hw/stageReg.sv */
`timescale 1ns/10ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
            outData  <= '0;
        end else begin
            outValid <= inValid;
            outData  <= inData;  // Taken every cycle, valid or not
        end
    end

endmodule

/* hw/aluControl.sv */
`timescale 1ns/10ps

module aluControl (
    input  aluPkg::aluReqT                  req,
    input  logic [aluPkg::dataWidth-1:0]    arithResult,
    input  logic                            arithCarry,
    input  logic                            arithOverflow,
    input  logic [aluPkg::dataWidth-1:0]    logicResult,
    output aluPkg::aluOpT                   unitOp,
    output logic [aluPkg::dataWidth-1:0]    unitA,
    output logic [aluPkg::dataWidth-1:0]    unitB,
    output logic                            unitCoe,
    output aluPkg::aluRespT                 resp
);

    import aluPkg::*;

    logic                 isArith;
    logic                 isLogic;
    logic [dataWidth-1:0] selResult;

    // Operation class decode
    always_comb begin
        isArith = 1'b0;
        isLogic = 1'b0;
        case (req.op)
            opAdd, opAddu, opSub, opSubu, opInc, opDec: isArith = 1'b1;
            opAnd, opOr, opXor, opShl:                  isLogic = 1'b1;
            default: ;  // Illegal code, neither class
        endcase
    end

    // Both units see the same operands
    assign unitOp  = req.op;
    assign unitA   = req.a;
    assign unitB   = req.b;
    assign unitCoe = req.coe;

    always_comb begin
        if (isArith) begin
            selResult = arithResult;
        end else if (isLogic) begin
            selResult = logicResult;
        end else begin
            selResult = '0;
        end
    end

    always_comb begin
        resp.result         = selResult;
        resp.flags.carry    = isArith & arithCarry;
        resp.flags.overflow = isArith & arithOverflow;
        resp.flags.zero     = (selResult == '0);
        resp.flags.negative = selResult[dataWidth-1];
    end

endmodule

/* hw/aluCore.sv */
`timescale 1ns/10ps

module aluCore #(
    parameter int dataWidth = aluPkg::dataWidth
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            reqValid,
    input  aluPkg::aluReqT  req,
    output logic            respValid,
    output aluPkg::aluRespT resp
);

    import aluPkg::*;

    logic                 s1Valid;
    aluReqT               s1Req;
    aluRespT              s2Resp;
    aluOpT                unitOp;
    logic [dataWidth-1:0] unitA;
    logic [dataWidth-1:0] unitB;
    logic                 unitCoe;
    logic [dataWidth-1:0] arithResult;
    logic                 arithCarry;
    logic                 arithOverflow;
    logic [dataWidth-1:0] logicResult;

    stageReg #(
        .payloadT(aluReqT)
    ) reqStage (
        .clk     (clk),
        .rst     (rst),
        .inValid (reqValid),
        .inData  (req),
        .outValid(s1Valid),
        .outData (s1Req)
    );

    aluControl control (
        .req          (s1Req),
        .arithResult  (arithResult),
        .arithCarry   (arithCarry),
        .arithOverflow(arithOverflow),
        .logicResult  (logicResult),
        .unitOp       (unitOp),
        .unitA        (unitA),
        .unitB        (unitB),
        .unitCoe      (unitCoe),
        .resp         (s2Resp)
    );

    addSubUnit #(
        .width(dataWidth)
    ) arith (
        .op      (unitOp),
        .a       (unitA),
        .b       (unitB),
        .coe     (unitCoe),
        .result  (arithResult),
        .carry   (arithCarry),
        .overflow(arithOverflow)
    );

    logicShiftUnit #(
        .width(dataWidth)
    ) logicShift (
        .op    (unitOp),
        .a     (unitA),
        .b     (unitB),
        .result(logicResult)
    );

    stageReg #(
        .payloadT(aluRespT)
    ) respStage (
        .clk     (clk),
        .rst     (rst),
        .inValid (s1Valid),
        .inData  (s2Resp),
        .outValid(respValid),
        .outData (resp)
    );

endmodule

/* tb/aluCore_properties.sv */
`timescale 1ns/10ps

module aluCore_properties (
    input logic            clk,
    input logic            rst,
    input logic            reqValid,
    input logic            respValid,
    input aluPkg::aluReqT  ctlReq,   // Request at the control module
    input aluPkg::aluRespT ctlResp   // Its response before the output stage
);

    import aluPkg::*;

    logic ctlArith;
    logic ctlSigned;
    logic ctlIllegal;
    int   failCount = 0;  // Assertion failures so far

    assign ctlArith   = ctlReq.op inside {opAdd, opAddu, opSub, opSubu, opInc, opDec};
    assign ctlSigned  = ctlReq.op inside {opAdd, opSub, opInc, opDec};
    assign ctlIllegal = 4'(ctlReq.op) > 4'd9;

    // Fixed two cycle latency with no extra strobes
    respTiming: assert property (@(posedge clk) disable iff (rst)
        respValid == $past(reqValid, 2))
        else begin
            failCount++;
            $error("respValid is not reqValid delayed by two cycles");
        end

    resetClear: assert property (@(posedge clk) rst |=> !respValid)
        else begin
            failCount++;
            $error("respValid high right after reset");
        end

    carryGate: assert property (@(posedge clk) disable iff (rst)
        (!ctlReq.coe || !ctlArith) |-> !ctlResp.flags.carry)
        else begin
            failCount++;
            $error("carry set with coe low or a non arithmetic op");
        end

    overflowGate: assert property (@(posedge clk) disable iff (rst)
        !ctlSigned |-> !ctlResp.flags.overflow)
        else begin
            failCount++;
            $error("overflow set for an op without signed overflow");
        end

    illegalOp: assert property (@(posedge clk) disable iff (rst)
        ctlIllegal |-> (ctlResp.result == '0 && ctlResp.flags == 4'b0010))
        else begin
            failCount++;
            $error("illegal op gave a result other than zero");
        end

endmodule

bind aluCore aluCore_properties props (
    .clk      (clk),
    .rst      (rst),
    .reqValid (reqValid),
    .respValid(respValid),
    .ctlReq   (s1Req),
    .ctlResp  (s2Resp)
);

/* tb/aluCoreTb.sv */
`timescale 1ns/10ps

module aluCoreTb;

    import aluPkg::*;

    localparam int numDirected   = 24;
    localparam int numRandom     = 300;
    localparam int timeoutCycles = (numDirected + numRandom) * 4 + 5 + 50;

    logic    clk;
    logic    rst;
    logic    reqValid;
    aluReqT  req;
    logic    respValid;
    aluRespT resp;

    integer  seed = 32'hd6d3;
    aluRespT expQ[$];  // Expected responses in request order
    aluRespT expResp;
    int      reqCount = 0;
    int      respCount = 0;
    int      mismatchCount = 0;
    int      strayCount = 0;
    int      endErrors = 0;

    aluCore #(
        .dataWidth(dataWidth)
    ) uut (
        .clk      (clk),
        .rst      (rst),
        .reqValid (reqValid),
        .req      (req),
        .respValid(respValid),
        .resp     (resp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Response predicted from the operation rules
    function automatic aluRespT expectedResp(input aluReqT r);
        aluRespT     e;
        logic [15:0] addB;  // Second adder operand
        logic [16:0] full;
        logic        arith;
        logic        signedOp;
        e        = '0;
        addB     = '0;
        arith    = 1'b1;
        signedOp = 1'b0;
        case (r.op)
            opAdd: begin
                addB     = r.b;
                signedOp = 1'b1;
            end
            opAddu: addB = r.b;
            opSub: begin
                addB     = 16'h0000 - r.b;
                signedOp = 1'b1;
            end
            opSubu: addB = 16'h0000 - r.b;
            opInc: begin
                addB     = 16'h0001;
                signedOp = 1'b1;
            end
            opDec: begin
                addB     = 16'hffff;
                signedOp = 1'b1;
            end
            default: arith = 1'b0;
        endcase
        full = {1'b0, r.a} + {1'b0, addB};
        if (arith) begin
            e.result         = full[15:0];
            e.flags.carry    = r.coe & full[16];
            e.flags.overflow = signedOp & (r.a[15] == addB[15]) & (full[15] != r.a[15]);
        end else begin
            case (r.op)
                opAnd:   e.result = r.a & r.b;
                opOr:    e.result = r.a | r.b;
                opXor:   e.result = r.a ^ r.b;
                opShl:   e.result = r.a << r.b[3:0];
                default: e.result = 16'h0000;  // Illegal code
            endcase
        end
        e.flags.zero     = (e.result == 16'h0000);
        e.flags.negative = e.result[15];
        return e;
    endfunction

    task automatic sendReq(input aluOpT op, input logic [15:0] a, input logic [15:0] b,
                           input logic coe);
        aluReqT r;
        r.op  = op;
        r.a   = a;
        r.b   = b;
        r.coe = coe;
        @(posedge clk);
        reqValid <= 1'b1;
        req      <= r;
        expQ.push_back(expectedResp(r));
        reqCount++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(posedge clk);
            reqValid <= 1'b0;
        end
    endtask

    // Corner operands sent back to back
    task automatic runDirected();
        sendReq(opAdd, 16'h7fff, 16'h0001, 1'b1);
        sendReq(opAddu, 16'h7fff, 16'h0001, 1'b1);
        sendReq(opAdd, 16'h8000, 16'hffff, 1'b1);
        sendReq(opSub, 16'h8000, 16'h0001, 1'b1);
        sendReq(opSubu, 16'h8000, 16'h0001, 1'b0);
        sendReq(opAdd, 16'h8000, 16'h8000, 1'b1);
        sendReq(opAddu, 16'h8000, 16'h8000, 1'b1);
        sendReq(opAdd, 16'h8000, 16'h8000, 1'b0);
        sendReq(opInc, 16'hffff, 16'h0000, 1'b1);
        sendReq(opInc, 16'h7fff, 16'h0000, 1'b0);
        sendReq(opDec, 16'h0000, 16'h0000, 1'b1);
        sendReq(opDec, 16'h8000, 16'h0000, 1'b1);
        sendReq(opSub, 16'h0000, 16'h0000, 1'b1);
        for (int c = 10; c < 16; c++) begin
            sendReq(aluOpT'(4'(c)), 16'h1234, 16'h8001, 1'b1);  // Illegal codes
        end
        sendReq(opAnd, 16'hff00, 16'h0ff0, 1'b1);
        sendReq(opOr, 16'hff00, 16'h0ff0, 1'b1);
        sendReq(opXor, 16'hffff, 16'hffff, 1'b1);
        sendReq(opShl, 16'h0001, 16'h000f, 1'b1);
        sendReq(opShl, 16'h0f0f, 16'h0013, 1'b1);  // Only B[3:0] used
    endtask

    task automatic runRandom();
        int gap;
        for (int i = 0; i < numRandom; i++) begin
            sendReq(aluOpT'(4'($random(seed))), 16'($random(seed)), 16'($random(seed)),
                    1'($random(seed)));
            gap = $unsigned($random(seed)) % 6;
            if (gap < 4) begin
                idleCycles(gap);
            end
        end
    endtask

    // Outputs are read mid-cycle
    always @(negedge clk) begin
        if (!rst && respValid) begin
            respCount++;
            if (expQ.size() == 0) begin
                strayCount++;
                $display("ERROR: response at %0t with no request pending", $time);
            end else begin
                expResp = expQ.pop_front();
                assert (resp == expResp) else begin
                    mismatchCount++;
                    $display("MISMATCH at %0t: got %h flags %b, expected %h flags %b",
                             $time, resp.result, resp.flags, expResp.result, expResp.flags);
                end
            end
        end
    end

    initial begin
        repeat (timeoutCycles) @(posedge clk);
        $display("ERROR: watchdog expired after %0d cycles, the run did not finish",
                 timeoutCycles);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        rst      = 1'b1;
        reqValid = 1'b0;
        req      = '0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        idleCycles(2);
        runDirected();
        runRandom();
        idleCycles(1);
        wait (respCount >= reqCount);
        idleCycles(4);  // Room for stray responses
        if (expQ.size() != 0) begin
            endErrors++;
            $display("ERROR: %0d expected responses never arrived", expQ.size());
        end
        if (respCount != reqCount) begin
            endErrors++;
            $display("ERROR: %0d requests sent but %0d responses seen", reqCount, respCount);
        end
        $display("Errors: mismatch %0d, unexpected responses %0d, end of run %0d, assertions %0d",
                 mismatchCount, strayCount, endErrors, uut.props.failCount);
        if (mismatchCount + strayCount + endErrors + uut.props.failCount == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* aluCore.f */
hw/aluPkg.sv
hw/cla16.sv
hw/addSubUnit.sv
hw/logicShiftUnit.sv
hw/stageReg.sv
hw/aluControl.sv
hw/aluCore.sv
tb/aluCore_properties.sv
tb/aluCoreTb.sv

/* Makefile */
TOP := aluCoreTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	rm -f sim.log
	verilator --binary --timing --assert --top-module $(TOP) -f aluCore.f -o simv
	./obj_dir/simv > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
	@cat sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log
